/* hw/mc_tx_cfg.svh */
`ifndef MC_TX_CFG_SVH
`define MC_TX_CFG_SVH

// data path and eva width
`define MC_DATA_W 32

// word address carried in a packet
`define MC_ADDR_W 28

// mesh coordinates
`define MC_X_W 4
`define MC_Y_W 4

// vcache banks across x, power of two only
`define MC_NUM_BANKS 4

// words per vcache block
`define MC_BLOCK_WORDS 8

// vcache capacity in words
`define MC_VCACHE_WORDS 1024

// outstanding request limit and counter width
`define MC_MAX_CREDITS 16
`define MC_CREDIT_W 5

// register id
`define MC_REG_W 5

`endif

/* hw/mc_tx_pkg.sv */
`default_nettype none

`include "mc_tx_cfg.svh"

package mc_tx_pkg;

  typedef enum logic [1:0] {
    op_load    = 2'd0,
    op_store   = 2'd1,
    op_swap_aq = 2'd2,
    op_swap_rl = 2'd3
  } packet_op_e;

  typedef enum logic [1:0] {
    class_dram     = 2'd0,
    class_global   = 2'd1,
    class_in_group = 2'd2,
    class_invalid  = 2'd3
  } addr_class_e;

  // request from the core
  typedef struct packed {
    logic                  write_not_read;
    logic                  swap_aq;
    logic                  swap_rl;
    logic [3:0]            mask;
    logic [`MC_DATA_W-1:0] payload;
    logic [`MC_DATA_W-1:0] addr;
  } remote_req_s;

  // travels with the request as its load id
  typedef struct packed {
    logic [`MC_REG_W-1:0] reg_id;
    logic                 float_wb;
    logic                 icache_fetch;
    logic                 is_unsigned;
    logic                 is_byte;
    logic                 is_hex;
    logic [1:0]           part_sel;
  } load_info_s;

  typedef struct packed {
    packet_op_e            op;
    logic [3:0]            op_ex;
    logic [`MC_DATA_W-1:0] payload;
    logic [`MC_Y_W-1:0]    src_y;
    logic [`MC_X_W-1:0]    src_x;
    logic [`MC_Y_W-1:0]    y;
    logic [`MC_X_W-1:0]    x;
    logic [`MC_ADDR_W-1:0] addr;
  } mc_packet_s;

endpackage

`default_nettype wire

/* hw/npa_if.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

// one network physical address, qualified by valid
interface npa_if;

  logic                  valid;
  logic [`MC_X_W-1:0]    x;
  logic [`MC_Y_W-1:0]    y;
  logic [`MC_ADDR_W-1:0] addr;

  modport src (
    output valid,
    output x,
    output y,
    output addr
  );

  modport dst (
    input valid,
    input x,
    input y,
    input addr
  );

endinterface

`default_nettype wire

/* hw/eva_decode.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module eva_decode import mc_tx_pkg::*; (
  input  wire [`MC_DATA_W-1:0] remote_addr_i,
  input  wire [`MC_X_W-1:0]    tgo_x_i,
  input  wire [`MC_Y_W-1:0]    tgo_y_i,
  output addr_class_e          addr_class_o,
  npa_if.src                   grp
);

  localparam int x_w    = `MC_X_W;
  localparam int y_w    = `MC_Y_W;
  localparam int addr_w = `MC_ADDR_W;

  logic       is_dram;
  logic       is_global;
  logic       is_in_group;
  logic [5:0] grp_x_sum;
  logic [4:0] grp_y_sum;

  assign is_dram     = remote_addr_i[31];
  assign is_global   = remote_addr_i[31:30] == 2'b01;
  assign is_in_group = remote_addr_i[31:29] == 3'b001;

  always_comb begin
    if (is_dram) begin
      addr_class_o = class_dram;
    end else if (is_global) begin
      addr_class_o = class_global;
    end else if (is_in_group) begin
      addr_class_o = class_in_group;
    end else begin
      addr_class_o = class_invalid;
    end
  end

  // group origin offset, wraps at the coordinate width
  assign grp_x_sum = remote_addr_i[23:18] + 6'(tgo_x_i);
  assign grp_y_sum = remote_addr_i[28:24] + 5'(tgo_y_i);

  always_comb begin
    grp.valid = (addr_class_o == class_global) || (addr_class_o == class_in_group);
    grp.addr  = addr_w'(remote_addr_i[17:2]);
    if (addr_class_o == class_in_group) begin
      grp.x = x_w'(grp_x_sum);
      grp.y = y_w'(grp_y_sum);
    end else begin
      grp.x = x_w'(remote_addr_i[23:18]);
      grp.y = y_w'(remote_addr_i[29:24]);
    end
  end

endmodule

`default_nettype wire

/* hw/dram_map.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module dram_map (
  input wire [`MC_DATA_W-1:0] remote_addr_i,
  input wire                  dram_enable_i,
  npa_if.src                  dram
);

  localparam int x_w    = `MC_X_W;
  localparam int y_w    = `MC_Y_W;
  localparam int addr_w = `MC_ADDR_W;
  localparam int bank_w = $clog2(`MC_NUM_BANKS);
  localparam int off_w  = $clog2(`MC_BLOCK_WORDS);
  localparam int vc_w   = $clog2(`MC_VCACHE_WORDS);
  // what is left after the dram bit, byte bits, block offset and bank
  localparam int idx_w  = `MC_DATA_W - 1 - 2 - off_w - bank_w;

  logic [bank_w-1:0] bank;
  logic [idx_w-1:0]  index;
  logic [off_w-1:0]  offset;

  // bank from the low bits, just above the block offset
  assign offset = remote_addr_i[2 +: off_w];
  assign bank   = remote_addr_i[2 + off_w +: bank_w];
  assign index  = remote_addr_i[2 + off_w + bank_w +: idx_w];

  always_comb begin
    dram.valid = remote_addr_i[31];
    if (dram_enable_i) begin
      dram.y    = {y_w{1'b1}};
      dram.x    = x_w'(bank);
      dram.addr = addr_w'({index, offset});
    end else if (remote_addr_i[30]) begin
      // host memory
      dram.y    = '0;
      dram.x    = '0;
      dram.addr = {1'b1, remote_addr_i[2 +: addr_w - 1]};
    end else begin
      // vcache addressed directly, no hashing
      dram.y    = {y_w{1'b1}};
      dram.x    = remote_addr_i[2 + vc_w +: x_w];
      dram.addr = addr_w'(remote_addr_i[2 +: vc_w]);
    end
  end

endmodule

`default_nettype wire

/* hw/packet_assemble.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module packet_assemble import mc_tx_pkg::*; (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire remote_req_s       remote_req_i,
  input  wire                    remote_req_v_i,
  input  wire [`MC_X_W-1:0]      my_x_i,
  input  wire [`MC_Y_W-1:0]      my_y_i,
  npa_if.dst                     grp,
  npa_if.dst                     dram,
  input  wire                    out_ready_i,
  input  wire                    credit_return_i,
  output mc_packet_s             out_packet_o,
  output logic                   out_v_o,
  output logic                   remote_req_yumi_o,
  output logic [`MC_CREDIT_W-1:0] out_credits_o
);

  localparam int credit_w = `MC_CREDIT_W;

  logic [credit_w-1:0] credits_q;

  always_comb begin
    if (remote_req_i.swap_aq) begin
      out_packet_o.op = op_swap_aq;
    end else if (remote_req_i.swap_rl) begin
      out_packet_o.op = op_swap_rl;
    end else if (remote_req_i.write_not_read) begin
      out_packet_o.op = op_store;
    end else begin
      out_packet_o.op = op_load;
    end

    out_packet_o.op_ex   = remote_req_i.mask;
    out_packet_o.payload = remote_req_i.payload;
    out_packet_o.src_y   = my_y_i;
    out_packet_o.src_x   = my_x_i;

    // the two sources never claim the same address
    if (dram.valid) begin
      out_packet_o.y    = dram.y;
      out_packet_o.x    = dram.x;
      out_packet_o.addr = dram.addr;
    end else if (grp.valid) begin
      out_packet_o.y    = grp.y;
      out_packet_o.x    = grp.x;
      out_packet_o.addr = grp.addr;
    end else begin
      out_packet_o.y    = '0;
      out_packet_o.x    = '0;
      out_packet_o.addr = '0;
    end
  end

  assign out_v_o           = remote_req_v_i & (|credits_q);
  assign remote_req_yumi_o = out_v_o & out_ready_i;

  // one credit per request in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_q <= credit_w'(`MC_MAX_CREDITS);
    end else begin
      case ({remote_req_yumi_o, credit_return_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  assign out_credits_o = credits_q;

endmodule

`default_nettype wire

/* hw/load_packer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module load_packer import mc_tx_pkg::*; (
  input  wire [`MC_DATA_W-1:0]  mem_data_i,
  input  wire load_info_s       load_info_i,
  output logic [`MC_DATA_W-1:0] load_data_o
);

  localparam int data_w = `MC_DATA_W;

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        byte_sign;
  logic        half_sign;

  assign byte_sel = mem_data_i[8*load_info_i.part_sel +: 8];
  // halfword picked by the upper part select bit
  assign half_sel = mem_data_i[16*load_info_i.part_sel[1] +: 16];

  assign byte_sign = ~load_info_i.is_unsigned & byte_sel[7];
  assign half_sign = ~load_info_i.is_unsigned & half_sel[15];

  always_comb begin
    if (load_info_i.is_byte) begin
      load_data_o = {{(data_w-8){byte_sign}}, byte_sel};
    end else if (load_info_i.is_hex) begin
      load_data_o = {{(data_w-16){half_sign}}, half_sel};
    end else begin
      load_data_o = mem_data_i;
    end
  end

endmodule

`default_nettype wire

/* hw/resp_demux.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module resp_demux import mc_tx_pkg::*; (
  input  wire                   returned_v_i,
  input  wire [`MC_DATA_W-1:0]  returned_data_i,
  input  wire load_info_s       returned_load_id_i,
  input  wire                   returned_fifo_full_i,
  input  wire                   int_yumi_i,
  output logic                  returned_yumi_o,
  output logic                  ifetch_v_o,
  output logic [`MC_DATA_W-1:0] ifetch_instr_o,
  output logic                  float_v_o,
  output logic [`MC_REG_W-1:0]  float_rd_o,
  output logic [`MC_DATA_W-1:0] float_data_o,
  output logic                  int_v_o,
  output logic [`MC_REG_W-1:0]  int_rd_o,
  output logic [`MC_DATA_W-1:0] int_data_o,
  output logic                  int_force_o
);

  load_packer u_load_packer (
    .mem_data_i  (returned_data_i),
    .load_info_i (returned_load_id_i),
    .load_data_o (int_data_o)
  );

  assign ifetch_instr_o = returned_data_i;
  assign float_data_o   = returned_data_i;
  assign float_rd_o     = returned_load_id_i.reg_id;
  assign int_rd_o       = returned_load_id_i.reg_id;

  always_comb begin
    ifetch_v_o  = 1'b0;
    float_v_o   = 1'b0;
    int_v_o     = 1'b0;
    int_force_o = 1'b0;
    if (returned_load_id_i.icache_fetch) begin
      ifetch_v_o      = returned_v_i;
      returned_yumi_o = returned_v_i;
    end else if (returned_load_id_i.float_wb) begin
      float_v_o       = returned_v_i;
      returned_yumi_o = returned_v_i;
    end else begin
      // a full fifo forces the int writeback to take it
      int_v_o         = returned_v_i;
      int_force_o     = returned_fifo_full_i & returned_v_i;
      returned_yumi_o = int_yumi_i | int_force_o;
    end
  end

endmodule

`default_nettype wire

/* hw/network_tx.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module network_tx import mc_tx_pkg::*; (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire remote_req_s        remote_req_i,
  input  wire                     remote_req_v_i,
  output logic                    remote_req_yumi_o,
  input  wire [`MC_X_W-1:0]       my_x_i,
  input  wire [`MC_Y_W-1:0]       my_y_i,
  input  wire [`MC_X_W-1:0]       tgo_x_i,
  input  wire [`MC_Y_W-1:0]       tgo_y_i,
  input  wire                     dram_enable_i,
  output addr_class_e             addr_class_o,
  output mc_packet_s              out_packet_o,
  output logic                    out_v_o,
  input  wire                     out_ready_i,
  input  wire                     credit_return_i,
  output logic [`MC_CREDIT_W-1:0] out_credits_o,
  input  wire                     returned_v_i,
  input  wire [`MC_DATA_W-1:0]    returned_data_i,
  input  wire load_info_s         returned_load_id_i,
  input  wire                     returned_fifo_full_i,
  output logic                    returned_yumi_o,
  output logic                    ifetch_v_o,
  output logic [`MC_DATA_W-1:0]   ifetch_instr_o,
  output logic                    float_v_o,
  output logic [`MC_REG_W-1:0]    float_rd_o,
  output logic [`MC_DATA_W-1:0]   float_data_o,
  output logic                    int_v_o,
  output logic [`MC_REG_W-1:0]    int_rd_o,
  output logic [`MC_DATA_W-1:0]   int_data_o,
  output logic                    int_force_o,
  input  wire                     int_yumi_i
);

  // destinations from the two decoders
  npa_if grp_npa ();
  npa_if dram_npa ();

  eva_decode u_eva_decode (
    .remote_addr_i (remote_req_i.addr),
    .tgo_x_i       (tgo_x_i),
    .tgo_y_i       (tgo_y_i),
    .addr_class_o  (addr_class_o),
    .grp           (grp_npa.src)
  );

  dram_map u_dram_map (
    .remote_addr_i (remote_req_i.addr),
    .dram_enable_i (dram_enable_i),
    .dram          (dram_npa.src)
  );

  packet_assemble u_packet_assemble (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .remote_req_i      (remote_req_i),
    .remote_req_v_i    (remote_req_v_i),
    .my_x_i            (my_x_i),
    .my_y_i            (my_y_i),
    .grp               (grp_npa.dst),
    .dram              (dram_npa.dst),
    .out_ready_i       (out_ready_i),
    .credit_return_i   (credit_return_i),
    .out_packet_o      (out_packet_o),
    .out_v_o           (out_v_o),
    .remote_req_yumi_o (remote_req_yumi_o),
    .out_credits_o     (out_credits_o)
  );

  resp_demux u_resp_demux (
    .returned_v_i         (returned_v_i),
    .returned_data_i      (returned_data_i),
    .returned_load_id_i   (returned_load_id_i),
    .returned_fifo_full_i (returned_fifo_full_i),
    .int_yumi_i           (int_yumi_i),
    .returned_yumi_o      (returned_yumi_o),
    .ifetch_v_o           (ifetch_v_o),
    .ifetch_instr_o       (ifetch_instr_o),
    .float_v_o            (float_v_o),
    .float_rd_o           (float_rd_o),
    .float_data_o         (float_data_o),
    .int_v_o              (int_v_o),
    .int_rd_o             (int_rd_o),
    .int_data_o           (int_data_o),
    .int_force_o          (int_force_o)
  );

endmodule

`default_nettype wire

/* testbench/network_tx_sva.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module network_tx_sva import mc_tx_pkg::*; (
  input wire                    clk_i,
  input wire                    rst_i,
  input wire                    remote_req_v_i,
  input wire                    out_ready_i,
  input wire                    credit_return_i,
  input wire                    out_v_o,
  input wire                    remote_req_yumi_o,
  input wire [`MC_CREDIT_W-1:0] out_credits_o,
  input wire addr_class_e       addr_class_o,
  input wire                    ifetch_v_o,
  input wire                    float_v_o,
  input wire                    int_v_o
);

  localparam int credit_w = `MC_CREDIT_W;

  yumi_needs_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    remote_req_yumi_o |-> out_v_o && out_ready_i)
    else $error("request taken without valid and ready");

  no_send_without_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    out_v_o |-> out_credits_o != '0)
    else $error("packet offered with no credit left");

  credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    out_credits_o <= credit_w'(`MC_MAX_CREDITS))
    else $error("credit count above its maximum");

  credit_spent: assert property (@(posedge clk_i) disable iff (rst_i)
    remote_req_yumi_o && !credit_return_i |=> out_credits_o == $past(out_credits_o) - credit_w'(1))
    else $error("accepted request did not spend a credit");

  credit_back: assert property (@(posedge clk_i) disable iff (rst_i)
    credit_return_i && !remote_req_yumi_o |=> out_credits_o == $past(out_credits_o) + credit_w'(1))
    else $error("credit return was lost");

  // invalid addresses get a zero destination and must not be requested
  valid_class: assert property (@(posedge clk_i) disable iff (rst_i)
    remote_req_v_i |-> addr_class_o != class_invalid)
    else $error("request to an invalid address");

  one_consumer: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({ifetch_v_o, float_v_o, int_v_o}))
    else $error("response routed to more than one consumer");

endmodule

bind network_tx network_tx_sva u_sva (.*);

`default_nettype wire

/* testbench/network_tx_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mc_tx_cfg.svh"

module network_tx_tb import mc_tx_pkg::*; ();

  localparam int clk_period = 40;
  localparam int n_req      = 10;
  localparam int n_resp     = 9;
  localparam int max_cred   = `MC_MAX_CREDITS;
  localparam int run_cycles = 2 + n_req + max_cred + 4 + n_resp;

  // ctl holds {v, write_not_read, swap_aq, swap_rl, dram_enable, ready}
  typedef struct packed {
    logic [31:0] addr;
    addr_class_e cls;
    logic [5:0]  ctl;
    logic [3:0]  mask;
    packet_op_e  op;
    logic [3:0]  x;
    logic [3:0]  y;
    logic [27:0] npa;
  } req_row_s;

  // route is {ifetch, float, int}
  typedef struct packed {
    logic        v;
    logic [31:0] data;
    load_info_s  id;
    logic        full;
    logic        int_yumi;
    logic [2:0]  route;
    logic        yumi;
    logic        frc;
    logic [31:0] value;
  } resp_row_s;

  logic                     clk_i;
  logic                     rst_i;
  remote_req_s              remote_req_i;
  logic                     remote_req_v_i;
  logic                     remote_req_yumi_o;
  logic [`MC_X_W-1:0]       my_x_i;
  logic [`MC_Y_W-1:0]       my_y_i;
  logic [`MC_X_W-1:0]       tgo_x_i;
  logic [`MC_Y_W-1:0]       tgo_y_i;
  logic                     dram_enable_i;
  addr_class_e              addr_class_o;
  mc_packet_s               out_packet_o;
  logic                     out_v_o;
  logic                     out_ready_i;
  logic                     credit_return_i;
  logic [`MC_CREDIT_W-1:0]  out_credits_o;
  logic                     returned_v_i;
  logic [`MC_DATA_W-1:0]    returned_data_i;
  load_info_s               returned_load_id_i;
  logic                     returned_fifo_full_i;
  logic                     returned_yumi_o;
  logic                     ifetch_v_o;
  logic [`MC_DATA_W-1:0]    ifetch_instr_o;
  logic                     float_v_o;
  logic [`MC_REG_W-1:0]     float_rd_o;
  logic [`MC_DATA_W-1:0]    float_data_o;
  logic                     int_v_o;
  logic [`MC_REG_W-1:0]     int_rd_o;
  logic [`MC_DATA_W-1:0]    int_data_o;
  logic                     int_force_o;
  logic                     int_yumi_i;

  req_row_s    req_tab [n_req];
  resp_row_s   resp_tab [n_resp];
  int          checks = 0;
  int          errors = 0;
  logic [31:0] rng = 32'd31047;

  network_tx UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin
    #((run_cycles + 40) * clk_period);
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("tests failed");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic load_info_s load_id(input logic [4:0] reg_id, input logic fw, input logic ic,
                                         input logic uns, input logic byt, input logic hex,
                                         input logic [1:0] part);
    load_info_s id;
    id = '{reg_id, fw, ic, uns, byt, hex, part};
    return id;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic fill_tables();
    // global, in-group with x wrap, opcode priority
    req_tab[0] = '{32'h521C_2AF0, class_global, 6'b100011, 4'hf, op_load,
                   4'h7, 4'h2, 28'h000_0ABC};
    req_tab[1] = '{32'h2E3C_48D0, class_in_group, 6'b110001, 4'h3, op_store,
                   4'h1, 4'hf, 28'h000_1234};
    req_tab[2] = '{32'h2100_0014, class_in_group, 6'b111001, 4'h1, op_swap_aq,
                   4'h2, 4'h2, 28'h000_0005};
    req_tab[3] = '{32'h7FFC_0004, class_global, 6'b110111, 4'hc, op_swap_rl,
                   4'hf, 4'hf, 28'h000_0001};
    // hashed dram
    req_tab[4] = '{32'h8091_A2D4, class_dram, 6'b100011, 4'hf, op_load,
                   4'h2, 4'hf, 28'h009_1A2D};
    req_tab[5] = '{32'hC000_00FC, class_dram, 6'b100011, 4'h0, op_load,
                   4'h3, 4'hf, 28'h400_000F};
    // host, then direct vcache
    req_tab[6] = '{32'hC123_4568, class_dram, 6'b110001, 4'hf, op_store,
                   4'h0, 4'h0, 28'h848_D15A};
    req_tab[7] = '{32'h8000_5ABC, class_dram, 6'b100001, 4'h1, op_load,
                   4'h5, 4'hf, 28'h000_02AF};
    // invalid class is never sent
    req_tab[8] = '{32'h1000_0000, class_invalid, 6'b000011, 4'h0, op_load,
                   4'h0, 4'h0, 28'h000_0000};
    // back-pressure
    req_tab[9] = '{32'h521C_2AF0, class_global, 6'b100000, 4'hf, op_load,
                   4'h7, 4'h2, 28'h000_0ABC};

    resp_tab[0] = '{1'b1, 32'h8421_F07E, load_id(7, 1, 1, 0, 0, 0, 0), 1'b1, 1'b0,
                    3'b100, 1'b1, 1'b0, 32'h8421_F07E};
    resp_tab[1] = '{1'b1, 32'h8421_F07E, load_id(9, 1, 0, 0, 0, 0, 0), 1'b1, 1'b0,
                    3'b010, 1'b1, 1'b0, 32'h8421_F07E};
    resp_tab[2] = '{1'b1, 32'h8421_F07E, load_id(4, 0, 0, 0, 1, 0, 1), 1'b0, 1'b1,
                    3'b001, 1'b1, 1'b0, 32'hFFFF_FFF0};
    resp_tab[3] = '{1'b1, 32'h8421_F07E, load_id(5, 0, 0, 1, 1, 0, 3), 1'b0, 1'b0,
                    3'b001, 1'b0, 1'b0, 32'h0000_0084};
    resp_tab[4] = '{1'b1, 32'h8421_F07E, load_id(6, 0, 0, 0, 0, 1, 2), 1'b1, 1'b0,
                    3'b001, 1'b1, 1'b1, 32'hFFFF_8421};
    resp_tab[5] = '{1'b1, 32'h8421_F07E, load_id(8, 0, 0, 1, 0, 1, 1), 1'b0, 1'b1,
                    3'b001, 1'b1, 1'b0, 32'h0000_F07E};
    resp_tab[6] = '{1'b1, 32'h8421_F07E, load_id(10, 0, 0, 0, 0, 0, 2), 1'b0, 1'b1,
                    3'b001, 1'b1, 1'b0, 32'h8421_F07E};
    resp_tab[7] = '{1'b0, 32'h8421_F07E, load_id(11, 0, 0, 0, 1, 0, 0), 1'b1, 1'b0,
                    3'b000, 1'b0, 1'b0, 32'h0};
    resp_tab[8] = '{1'b0, 32'h8421_F07E, load_id(1, 0, 1, 0, 0, 0, 0), 1'b0, 1'b1,
                    3'b000, 1'b0, 1'b0, 32'h0};
  endtask

  initial begin
    remote_req_s req;
    req_row_s    r;
    resp_row_s   s;
    int          i;

    fill_tables();
    rst_i                = 1'b1;
    remote_req_i         = '0;
    remote_req_v_i       = 1'b0;
    my_x_i               = 4'd3;
    my_y_i               = 4'd5;
    tgo_x_i              = 4'd2;
    tgo_y_i              = 4'd1;
    dram_enable_i        = 1'b0;
    out_ready_i          = 1'b0;
    credit_return_i      = 1'b0;
    returned_v_i         = 1'b0;
    returned_data_i      = '0;
    returned_load_id_i   = '0;
    returned_fifo_full_i = 1'b0;
    int_yumi_i           = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // request table with a credit back for every accepted request
    for (i = 0; i < n_req; i++) begin
      r   = req_tab[i];
      rng = xorshift(rng);
      req.write_not_read = r.ctl[4];
      req.swap_aq        = r.ctl[3];
      req.swap_rl        = r.ctl[2];
      req.mask           = r.mask;
      req.payload        = rng;
      req.addr           = r.addr;
      @(posedge clk_i);
      remote_req_i    <= req;
      remote_req_v_i  <= r.ctl[5];
      dram_enable_i   <= r.ctl[1];
      out_ready_i     <= r.ctl[0];
      credit_return_i <= r.ctl[5] & r.ctl[0];
      @(negedge clk_i);
      compare($sformatf("req %0d class", i), 32'(addr_class_o), 32'(r.cls));
      compare($sformatf("req %0d op", i), 32'(out_packet_o.op), 32'(r.op));
      compare($sformatf("req %0d op_ex", i), 32'(out_packet_o.op_ex), 32'(r.mask));
      compare($sformatf("req %0d payload", i), out_packet_o.payload, req.payload);
      compare($sformatf("req %0d src_x", i), 32'(out_packet_o.src_x), 32'd3);
      compare($sformatf("req %0d src_y", i), 32'(out_packet_o.src_y), 32'd5);
      compare($sformatf("req %0d x", i), 32'(out_packet_o.x), 32'(r.x));
      compare($sformatf("req %0d y", i), 32'(out_packet_o.y), 32'(r.y));
      compare($sformatf("req %0d addr", i), 32'(out_packet_o.addr), 32'(r.npa));
      compare($sformatf("req %0d out_v", i), 32'(out_v_o), 32'(r.ctl[5]));
      compare($sformatf("req %0d yumi", i), 32'(remote_req_yumi_o), 32'(r.ctl[5] & r.ctl[0]));
      compare($sformatf("req %0d credits", i), 32'(out_credits_o), 32'(max_cred));
    end

    // spend every credit with none returned
    for (i = 0; i < max_cred; i++) begin
      @(posedge clk_i);
      remote_req_v_i  <= 1'b1;
      out_ready_i     <= 1'b1;
      credit_return_i <= 1'b0;
      @(negedge clk_i);
      compare($sformatf("drain %0d credits", i), 32'(out_credits_o), 32'(max_cred - i));
      compare($sformatf("drain %0d out_v", i), 32'(out_v_o), 32'd1);
      compare($sformatf("drain %0d yumi", i), 32'(remote_req_yumi_o), 32'd1);
    end
    repeat (2) begin
      @(posedge clk_i);
      @(negedge clk_i);
      compare("empty credits", 32'(out_credits_o), 32'd0);
      compare("empty out_v", 32'(out_v_o), 32'd0);
      compare("empty yumi", 32'(remote_req_yumi_o), 32'd0);
    end
    @(posedge clk_i);
    credit_return_i <= 1'b1;
    @(posedge clk_i);
    credit_return_i <= 1'b0;
    out_ready_i     <= 1'b0;
    @(negedge clk_i);
    compare("returned credits", 32'(out_credits_o), 32'd1);
    compare("returned out_v", 32'(out_v_o), 32'd1);
    compare("returned yumi", 32'(remote_req_yumi_o), 32'd0);

    // response routing
    for (i = 0; i < n_resp; i++) begin
      s = resp_tab[i];
      @(posedge clk_i);
      remote_req_v_i       <= 1'b0;
      returned_v_i         <= s.v;
      returned_data_i      <= s.data;
      returned_load_id_i   <= s.id;
      returned_fifo_full_i <= s.full;
      int_yumi_i           <= s.int_yumi;
      @(negedge clk_i);
      compare($sformatf("resp %0d ifetch_v", i), 32'(ifetch_v_o), 32'(s.route[2]));
      compare($sformatf("resp %0d float_v", i), 32'(float_v_o), 32'(s.route[1]));
      compare($sformatf("resp %0d int_v", i), 32'(int_v_o), 32'(s.route[0]));
      compare($sformatf("resp %0d yumi", i), 32'(returned_yumi_o), 32'(s.yumi));
      compare($sformatf("resp %0d force", i), 32'(int_force_o), 32'(s.frc));
      if (s.route[2]) begin
        compare($sformatf("resp %0d instr", i), ifetch_instr_o, s.value);
      end
      if (s.route[1]) begin
        compare($sformatf("resp %0d float data", i), float_data_o, s.value);
        compare($sformatf("resp %0d float rd", i), 32'(float_rd_o), 32'(s.id.reg_id));
      end
      if (s.route[0]) begin
        compare($sformatf("resp %0d int data", i), int_data_o, s.value);
        compare($sformatf("resp %0d int rd", i), 32'(int_rd_o), 32'(s.id.reg_id));
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/mc_tx_pkg.sv
hw/npa_if.sv
hw/eva_decode.sv
hw/dram_map.sv
hw/packet_assemble.sv
hw/load_packer.sv
hw/resp_demux.sv
hw/network_tx.sv
testbench/network_tx_sva.sv
testbench/network_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the network_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f vlog.f --top-module network_tx_tb \
  -Mdir obj_dir -o network_tx_sim
if [ $? -ne 0 ]; then
  echo "verilator compile step returned an error"
  exit 1
fi

./obj_dir/network_tx_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$log"; then
  exit 1
fi
exit 0
